//--- hdl/uart_params.svh
/* Compile-time UART constants. UART_CLKS_PER_BIT must be even and at least 4
   so that the receiver's half-bit sample point is exact */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ------------------------------------------------------------
// Serial line timing
// ------------------------------------------------------------

// Clock cycles per serial bit, kept short for simulation
`define UART_CLKS_PER_BIT 16

// Data bits per frame, format is fixed 8N1
`define UART_DATA_BITS 8

// ------------------------------------------------------------
// Bus geometry
// ------------------------------------------------------------

// Word address width of the register window
`define UART_ADR_BITS 2

`endif

//--- hdl/uart_bus_pkg.sv
/* Register map, decoded bus operations and status bit layout of the UART */
`default_nettype none

package uart_bus_pkg;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    REG_DATA   = 2'd0,
    REG_STATUS = 2'd1,
    REG_RSVD2  = 2'd2,
    REG_RSVD3  = 2'd3
  } uart_reg_e;

  // One-cycle operation issued alongside ack
  typedef enum logic [2:0] {
    OP_NONE,
    OP_TX_WRITE,
    OP_RX_READ,
    OP_STAT_READ,
    OP_STAT_CLEAR,
    OP_UNMAPPED
  } wb_op_e;

  // Bit positions inside the status byte
  localparam int STAT_TX_BUSY   = 0;
  localparam int STAT_RX_VALID  = 1;
  localparam int STAT_OVERRUN   = 2;
  localparam int STAT_FRAME_ERR = 3;

endpackage

`default_nettype wire

//--- hdl/uart_line_pkg.sv
/* State encodings of the transmit and receive line engines */
`default_nettype none

package uart_line_pkg;

  // Transmitter controller
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_LOAD,
    TX_SHIFT
  } tx_state_e;

  // Receiver controller
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

//--- hdl/uart_baud_tick.sv
/* Bit-rate divider. With half set the first tick after enable comes at half a bit */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_baud_tick #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  wire  clk,
  input  wire  rstn,
  input  wire  en,
  input  wire  half,
  output logic tick
);

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] FULL_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

  logic [CW-1:0] cnt;
  logic          first;
  logic [CW-1:0] last;

  // Terminal count, shortened for the first period in half mode
  assign last = (half && first) ? HALF_LAST : FULL_LAST;
  assign tick = en && (cnt == last);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt   <= '0;
      first <= 1'b1;
    end else if (!en) begin
      // Restart so every enable begins a fresh bit
      cnt   <= '0;
      first <= 1'b1;
    end else if (tick) begin
      cnt   <= '0;
      first <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_wb_decode.sv
/* Wishbone classic slave, every access acked after one cycle with no wait states.
   Master must hold cyc, stb, we, adr and dat_w steady until ack */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_wb_decode
  import uart_bus_pkg::*;
(
  input  wire                        clk,
  input  wire                        rstn,
  input  wire                        wb_cyc,
  input  wire                        wb_stb,
  input  wire                        wb_we,
  input  wire [`UART_ADR_BITS-1:0]   wb_adr,
  input  wire [`UART_DATA_BITS-1:0]  wb_dat_w,
  output logic                       wb_ack,
  output wb_op_e                     op,
  output logic [`UART_DATA_BITS-1:0] tx_byte
);

  logic      access;
  uart_reg_e reg_sel;
  wb_op_e    op_next;

  // ------------------------------------------------------------
  // Address and direction decode
  // ------------------------------------------------------------

  // New access only while ack is low, so a held stb is not counted twice
  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign reg_sel = uart_reg_e'(wb_adr);

  always_comb begin
    case (reg_sel)
      REG_DATA: begin
        op_next = wb_we ? OP_TX_WRITE : OP_RX_READ;
      end
      REG_STATUS: begin
        // Writing status clears the sticky error flags
        op_next = wb_we ? OP_STAT_CLEAR : OP_STAT_READ;
      end
      default: begin
        // Reserved words still get acked
        op_next = OP_UNMAPPED;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Ack and operation pulse, raised on the same edge
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb_ack <= 1'b0;
      op     <= OP_NONE;
    end else begin
      wb_ack <= access;
      op     <= access ? op_next : OP_NONE;
    end
  end

  // Write byte for the transmitter, held until the next write
  always_ff @(posedge clk) begin
    if (access && wb_we) begin
      tx_byte <= wb_dat_w;
    end
  end

  // Single-cycle ack even though stb is still high in the ack cycle
  a_ack_single: assert property (@(posedge clk) disable iff (!rstn)
    wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
/* 8N1 transmitter. A write while a frame is in flight is ignored, no queueing */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_tx
  import uart_bus_pkg::*, uart_line_pkg::*;
(
  input  wire                       clk,
  input  wire                       rstn,
  input  var wb_op_e                op,
  input  wire [`UART_DATA_BITS-1:0] tx_byte,
  output logic                      tx,
  output logic                      busy
);

  // Start bit, data bits, stop bit
  localparam int FRAME_BITS = `UART_DATA_BITS + 2;
  localparam int BCW        = $clog2(FRAME_BITS);

  tx_state_e             state;
  logic [FRAME_BITS-1:0] shifter;
  logic [BCW-1:0]        bitc;
  logic                  tick_en_tx;
  logic                  tick;
  logic                  last_tick;
  logic                  tail;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  // Divider only runs while shifting, so each frame starts on a full bit
  assign tick_en_tx = (state == TX_SHIFT);
  assign last_tick  = tick && (bitc == BCW'(FRAME_BITS - 1));
  // Tail covers the cycle in which the registered line still shows the stop bit
  assign busy       = (state != TX_IDLE) || tail;

  uart_baud_tick #(
    .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
  ) u_baud (
    .clk  (clk),
    .rstn (rstn),
    .en   (tick_en_tx),
    .half (1'b0),
    .tick (tick)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= TX_IDLE;
      tail  <= 1'b0;
    end else begin
      tail <= last_tick;
      case (state)
        TX_IDLE:  if (op == OP_TX_WRITE && !tail) state <= TX_LOAD;
        // One cycle to load the frame
        TX_LOAD:  state <= TX_SHIFT;
        TX_SHIFT: if (last_tick) state <= TX_IDLE;
        default:  state <= TX_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------

  // Frame goes out LSB first, ones fill from the top so the line idles high
  always_ff @(posedge clk) begin
    if (!rstn) begin
      shifter <= '1;
      bitc    <= '0;
    end else if (state == TX_LOAD) begin
      shifter <= {1'b1, tx_byte, 1'b0};
      bitc    <= '0;
    end else if (tick) begin
      shifter <= {1'b1, shifter[FRAME_BITS-1:1]};
      bitc    <= bitc + 1'b1;
    end
  end

  // Registered line output, glitch free
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tx <= 1'b1;
    end else begin
      tx <= shifter[0];
    end
  end

  // Line is at mark once the controller has settled in idle
  a_idle_mark: assert property (@(posedge clk) disable iff (!rstn)
    (state == TX_IDLE && $past(state) == TX_IDLE) |-> tx);

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
/* 8N1 receiver sampling at mid-bit. Low pulses shorter than half a bit are dropped,
   a bad stop bit discards the byte */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_rx
  import uart_line_pkg::*;
(
  input  wire                        clk,
  input  wire                        rstn,
  input  wire                        rx,
  output logic                       rx_done,
  output logic [`UART_DATA_BITS-1:0] rx_byte,
  output logic                       rx_ferr
);

  localparam int BCW = $clog2(`UART_DATA_BITS);

  rx_state_e                  state;
  logic                       rx_s1;
  logic                       rx_s2;
  logic                       rx_d;
  logic                       fall;
  logic                       tick;
  logic [BCW-1:0]             bitc;
  logic [`UART_DATA_BITS-1:0] shreg;

  // ------------------------------------------------------------
  // Input synchronizer and edge detect
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  assign fall = rx_d && !rx_s2;

  // Half mode puts every tick at a bit centre
  uart_baud_tick #(
    .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
  ) u_baud (
    .clk  (clk),
    .rstn (rstn),
    .en   (state != RX_IDLE),
    .half (1'b1),
    .tick (tick)
  );

  // ------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= RX_IDLE;
      bitc    <= '0;
      rx_done <= 1'b0;
      rx_ferr <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      rx_ferr <= 1'b0;
      case (state)
        RX_IDLE: if (fall) state <= RX_START;
        RX_START: begin
          // Line back high at mid start bit, treat as glitch
          if (tick) begin
            state <= rx_s2 ? RX_IDLE : RX_DATA;
            bitc  <= '0;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bitc <= bitc + 1'b1;
            if (bitc == BCW'(`UART_DATA_BITS - 1)) state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (tick) begin
            state   <= RX_IDLE;
            rx_done <= rx_s2;
            rx_ferr <= !rx_s2;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && tick) begin
      shreg <= {rx_s2, shreg[`UART_DATA_BITS-1:1]};
    end
  end

  // Shift register is stable from the last data bit until the next frame
  assign rx_byte = shreg;

  a_done_xor_ferr: assert property (@(posedge clk) disable iff (!rstn)
    !(rx_done && rx_ferr));

endmodule

`default_nettype wire

//--- hdl/uart_status.sv
/* Single-byte receive holding register and sticky flags. Read data is only
   meaningful in the ack cycle and is zero otherwise */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_status
  import uart_bus_pkg::*;
(
  input  wire                        clk,
  input  wire                        rstn,
  input  var wb_op_e                 op,
  input  wire                        busy,
  input  wire                        rx_done,
  input  wire [`UART_DATA_BITS-1:0]  rx_byte,
  input  wire                        rx_ferr,
  output logic [`UART_DATA_BITS-1:0] wb_dat_r
);

  logic [`UART_DATA_BITS-1:0] hold;
  logic                       rx_valid;
  logic                       overrun;
  logic                       frame_err;
  logic [`UART_DATA_BITS-1:0] stat_byte;

  // ------------------------------------------------------------
  // Receive holding register and flags
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_valid  <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      if (rx_done) begin
        // Unread byte still held, new one is lost
        if (rx_valid && op != OP_RX_READ) overrun <= 1'b1;
        else rx_valid <= 1'b1;
      end else if (op == OP_RX_READ) begin
        rx_valid <= 1'b0;
      end
      if (rx_ferr) begin
        frame_err <= 1'b1;
      end else if (op == OP_STAT_CLEAR) begin
        frame_err <= 1'b0;
      end
      // A new overrun in the clear cycle wins
      if (op == OP_STAT_CLEAR && !(rx_done && rx_valid)) begin
        overrun <= 1'b0;
      end
    end
  end

  // Byte is kept after a read, so a second read returns it again
  always_ff @(posedge clk) begin
    if (rx_done && (!rx_valid || op == OP_RX_READ)) begin
      hold <= rx_byte;
    end
  end

  // ------------------------------------------------------------
  // Read data mux
  // ------------------------------------------------------------
  always_comb begin
    stat_byte                 = '0;
    stat_byte[STAT_TX_BUSY]   = busy;
    stat_byte[STAT_RX_VALID]  = rx_valid;
    stat_byte[STAT_OVERRUN]   = overrun;
    stat_byte[STAT_FRAME_ERR] = frame_err;
    case (op)
      OP_RX_READ:   wb_dat_r = hold;
      OP_STAT_READ: wb_dat_r = stat_byte;
      default:      wb_dat_r = '0;
    endcase
  end

  // Only a DATA read consumes the held byte
  a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
    (rx_valid && op != OP_RX_READ) |=> rx_valid);

endmodule

`default_nettype wire

//--- hdl/uart_top.sv
/* UART on an 8-bit Wishbone classic bus, fixed 8N1 at a compile-time bit rate.
   No parity, FIFOs, interrupts or flow control */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_top
  import uart_bus_pkg::*;
(
  input  wire                        clk,
  input  wire                        rstn,
  input  wire                        wb_cyc,
  input  wire                        wb_stb,
  input  wire                        wb_we,
  input  wire [`UART_ADR_BITS-1:0]   wb_adr,
  input  wire [`UART_DATA_BITS-1:0]  wb_dat_w,
  input  wire                        rx,
  output logic [`UART_DATA_BITS-1:0] wb_dat_r,
  output logic                       wb_ack,
  output logic                       tx
);

  wb_op_e                     op;
  logic [`UART_DATA_BITS-1:0] tx_byte;
  logic                       busy;
  logic                       rx_done;
  logic [`UART_DATA_BITS-1:0] rx_byte;
  logic                       rx_ferr;

  // ------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------
  uart_wb_decode u_decode (
    .clk      (clk),
    .rstn     (rstn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .op       (op),
    .tx_byte  (tx_byte)
  );

  // Line engines, each with its own divider
  uart_tx u_tx (
    .clk     (clk),
    .rstn    (rstn),
    .op      (op),
    .tx_byte (tx_byte),
    .tx      (tx),
    .busy    (busy)
  );

  uart_rx u_rx (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_byte (rx_byte),
    .rx_ferr (rx_ferr)
  );

  // Flags and read data
  uart_status u_status (
    .clk      (clk),
    .rstn     (rstn),
    .op       (op),
    .busy     (busy),
    .rx_done  (rx_done),
    .rx_byte  (rx_byte),
    .rx_ferr  (rx_ferr),
    .wb_dat_r (wb_dat_r)
  );

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
/* Testbench clock of 10 ns and a synchronous active-low reset held for 4 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  // Free-running clock, first rising edge at 5 ns
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after the fourth rising edge
  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_uart_top.sv
/* Self-checking testbench for uart_top, bit time taken from UART_CLKS_PER_BIT at a
   10 ns clock. Inputs change 1 ns after the rising edge, random data from LCG seed 78 */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module tb_uart_top
  import uart_bus_pkg::*;
();

  localparam int  CPB        = `UART_CLKS_PER_BIT;
  localparam int  CLK_NS     = 10;
  localparam int  BIT_NS     = CPB * CLK_NS;
  localparam int  N_TX       = 12;
  localparam int  N_RX       = 12;
  // Transmit, receive, overrun pair, bad stop bit, glitch window, write while busy, idle check
  localparam int  N_FRAMES   = N_TX + N_RX + 2 + 1 + 1 + 1 + 1;
  localparam time WATCHDOG_NS = 2 * (N_FRAMES * 10 * BIT_NS) + 10000;
  // Status reads allowed while waiting on one frame
  localparam int  POLL_LIMIT = 12 * CPB;

  logic       clk;
  logic       rstn;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [1:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic       wb_ack;
  logic       rx;
  logic       tx;

  // Reference model of the receive flags and holding byte
  logic       m_rx_valid;
  logic       m_overrun;
  logic       m_frame_err;
  logic [7:0] m_hold;

  // Frames decoded by the tx monitor
  logic [7:0] mon_byte_q[$];
  logic       mon_stop_q[$];
  time        mon_start_q[$];

  time         last_ack_ns;
  logic [31:0] lcg_state = 32'd78;

  tb_clkgen u_clkgen (
    .clk  (clk),
    .rstn (rstn)
  );

  uart_top u_uart_top (
    .clk      (clk),
    .rstn     (rstn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .rx       (rx),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .tx       (tx)
  );

  // ------------------------------------------------------------
  // Random numbers and error reporting
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = lcg_next();
    return r[23:16];
  endfunction

  // Idle gap of 0 to 15 cycles
  function automatic int gap_cycles();
    logic [31:0] r;
    r = lcg_next();
    return int'(r[19:16]);
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0d ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    assert (got === exp)
    else report_error($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
  endtask

  // ------------------------------------------------------------
  // Receive model
  // ------------------------------------------------------------
  task automatic predict_frame(input logic [7:0] b, input logic stop);
    if (!stop) begin
      m_frame_err = 1'b1;
    end else if (m_rx_valid) begin
      // Old byte is kept and the new one lost
      m_overrun = 1'b1;
    end else begin
      m_rx_valid = 1'b1;
      m_hold     = b;
    end
  endtask

  function automatic logic [7:0] expected_status(input logic busy);
    logic [7:0] s;
    s                 = '0;
    s[STAT_TX_BUSY]   = busy;
    s[STAT_RX_VALID]  = m_rx_valid;
    s[STAT_OVERRUN]   = m_overrun;
    s[STAT_FRAME_ERR] = m_frame_err;
    return s;
  endfunction

  // ------------------------------------------------------------
  // Wishbone master
  // ------------------------------------------------------------

  // Stays aligned to 1 ns after the rising edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wb_access(input logic we, input uart_reg_e adr, input logic [7:0] wdata,
                           output logic [7:0] rdata);
    int waited;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_ack && waited < 2);
    assert (wb_ack === 1'b1)
    else report_error($sformatf("no ack within 2 cycles for an access to address %0d", adr));
    rdata       = wb_dat_r;
    last_ack_ns = $time - 1;
    // Drop the strobe in the cycle after ack
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input uart_reg_e adr, input logic [7:0] data);
    logic [7:0] rd_ignored;
    wb_access(1'b1, adr, data, rd_ignored);
  endtask

  task automatic read_reg(input uart_reg_e adr, output logic [7:0] data);
    wb_access(1'b0, adr, 8'h00, data);
  endtask

  task automatic status_check(input logic busy, input string what);
    logic [7:0] rd;
    read_reg(REG_STATUS, rd);
    check_byte(rd, expected_status(busy), what);
  endtask

  task automatic read_data_check(input string what);
    logic [7:0] rd;
    read_reg(REG_DATA, rd);
    check_byte(rd, m_hold, what);
    m_rx_valid = 1'b0;
  endtask

  task automatic status_clear();
    write_reg(REG_STATUS, 8'h00);
    m_overrun   = 1'b0;
    m_frame_err = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Serial line model and tx monitor
  // ------------------------------------------------------------
  task automatic send_frame(input logic [7:0] b, input logic stop);
    int i;
    rx = 1'b0;
    #(BIT_NS);
    for (i = 0; i < 8; i++) begin
      rx = b[i];
      #(BIT_NS);
    end
    rx = stop;
    #(BIT_NS);
    rx = 1'b1;
    predict_frame(b, stop);
  endtask

  initial begin : tx_monitor
    logic [7:0] b;
    logic       stop;
    time        t0;
    int         i;
    forever begin
      @(negedge tx);
      t0 = $time;
      // Sample at mid-bit 1 ns past the edge
      #(BIT_NS / 2 + 1);
      assert (tx === 1'b0) else report_error("tx start bit was not low at its midpoint");
      for (i = 0; i < 8; i++) begin
        #(BIT_NS);
        b[i] = tx;
      end
      #(BIT_NS);
      stop = tx;
      mon_byte_q.push_back(b);
      mon_stop_q.push_back(stop);
      mon_start_q.push_back(t0);
    end
  end

  task automatic wait_tx_idle();
    logic [7:0] rd;
    int         polls;
    polls = 0;
    do begin
      read_reg(REG_STATUS, rd);
      polls++;
      assert (polls <= POLL_LIMIT) else report_error("tx busy never cleared while polling");
    end while (rd[STAT_TX_BUSY]);
    check_byte(rd, expected_status(1'b0), "status once tx is idle");
  endtask

  task automatic check_tx_frame(input logic [7:0] b, input time ack_t);
    logic [7:0] got;
    logic       stop;
    time        t0;
    assert (mon_byte_q.size() == 1)
    else report_error($sformatf("monitor holds %0d frames, expected 1", mon_byte_q.size()));
    got  = mon_byte_q.pop_front();
    stop = mon_stop_q.pop_front();
    t0   = mon_start_q.pop_front();
    check_byte(got, b, "byte decoded from tx");
    assert (stop === 1'b1) else report_error("tx stop bit was not high");
    assert (t0 > ack_t && t0 - ack_t <= 3 * CLK_NS)
    else report_error($sformatf("start bit %0d ns after the write ack", t0 - ack_t));
  endtask

  task automatic wait_rx_valid();
    logic [7:0] rd;
    int         polls;
    polls = 0;
    do begin
      read_reg(REG_STATUS, rd);
      polls++;
      assert (polls <= POLL_LIMIT) else report_error("rx_valid never set while polling");
    end while (!rd[STAT_RX_VALID]);
  endtask

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : main_seq
    logic [7:0] rd;
    logic [7:0] b;
    logic [7:0] first_b;
    time        ack_t;
    int         n;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    rx          = 1'b1;
    m_rx_valid  = 1'b0;
    m_overrun   = 1'b0;
    m_frame_err = 1'b0;
    m_hold      = '0;
    @(posedge rstn);
    idle_cycles(2);

    // Reset values
    assert (tx === 1'b1) else report_error("tx not high after reset");
    assert (wb_ack === 1'b0) else report_error("wb_ack not low after reset");
    status_check(1'b0, "status after reset");

    // Transmit path
    for (n = 0; n < N_TX; n++) begin
      b = rand_byte();
      write_reg(REG_DATA, b);
      ack_t = last_ack_ns;
      status_check(1'b1, "status right after DATA write");
      wait_tx_idle();
      check_tx_frame(b, ack_t);
      idle_cycles(gap_cycles());
    end

    // Receive path
    for (n = 0; n < N_RX; n++) begin
      b = rand_byte();
      send_frame(b, 1'b1);
      wait_rx_valid();
      read_data_check("received byte");
      status_check(1'b0, "status after DATA read");
      idle_cycles(gap_cycles());
    end

    // Overrun where the second byte is dropped
    first_b = rand_byte();
    b       = rand_byte();
    send_frame(first_b, 1'b1);
    idle_cycles(gap_cycles());
    send_frame(b, 1'b1);
    idle_cycles(CPB + 4);
    status_check(1'b0, "status after overrun");
    read_data_check("byte kept on overrun");
    status_clear();
    status_check(1'b0, "status after clearing overrun");

    // Bad stop bit followed by a quarter-bit glitch
    send_frame(rand_byte(), 1'b0);
    idle_cycles(CPB + 4);
    status_check(1'b0, "status after bad stop bit");
    read_data_check("DATA read with rx_valid low");
    rx = 1'b0;
    #(BIT_NS / 4);
    rx = 1'b1;
    // Long enough for a falsely started frame to finish
    idle_cycles(11 * CPB);
    status_check(1'b0, "status after short low pulse");
    status_clear();
    status_check(1'b0, "status after clearing frame error");

    // Reserved words
    read_reg(REG_RSVD2, rd);
    check_byte(rd, 8'h00, "read of address 2");
    read_reg(REG_RSVD3, rd);
    check_byte(rd, 8'h00, "read of address 3");
    write_reg(REG_RSVD2, rand_byte());
    write_reg(REG_RSVD3, rand_byte());
    status_check(1'b0, "status after reserved writes");

    // Write during a frame is dropped
    first_b = rand_byte();
    write_reg(REG_DATA, first_b);
    ack_t = last_ack_ns;
    idle_cycles(3 * CPB);
    status_check(1'b1, "status mid frame");
    write_reg(REG_DATA, ~first_b);
    wait_tx_idle();
    check_tx_frame(first_b, ack_t);
    // A wrongly started frame would be fully decoded by now
    idle_cycles(11 * CPB);
    assert (mon_byte_q.size() == 0) else report_error("dropped write started a frame");
    assert (tx === 1'b1) else report_error("tx not idle after the dropped write");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/uart_bus_pkg.sv
hdl/uart_line_pkg.sv
hdl/uart_baud_tick.sv
hdl/uart_wb_decode.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_status.sv
hdl/uart_top.sv
test/tb_clkgen.sv
test/tb_uart_top.sv
